// File: Makefile
TOP := cache_tb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: list.f
+incdir+logic
logic/cache_pkg.sv
logic/sram_array.sv
logic/victim_sel.sv
logic/tag_cmp.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/cache_sva.sv
verif/cache_tb.sv

// File: logic/cache_ctrl.sv
/*
 * cache lookup control
 * response credit counter, arbitration enable and response assembly
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl import cache_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               credit_i,
  input  logic                               gnt_i,
  input  logic                               fill_i,
  input  logic  [`CACHE_SET_ASSOC-1:0]       victim_way_i,
  input  line_t                              fill_data_i,
  input  logic  [`CACHE_SET_ASSOC-1:0]       hit_way_i,
  input  logic  [`CACHE_NR_PORTS-1:0]        sel_id_i,
  input  line_t [`CACHE_SET_ASSOC-1:0]       line_rdata_i,
  output logic                               arb_en_o,
  output logic                               resp_valid_o,
  output cache_resp_t                        resp_o
);

  localparam int unsigned CreditWidth = `CACHE_CREDIT_WIDTH;
  localparam logic [CreditWidth-1:0] MaxCredits = CreditWidth'(`CACHE_RESP_CREDITS);

  logic [CreditWidth-1:0] credit_q;
  logic [CreditWidth-1:0] credit_d;
  logic                   pending_q;
  logic                   fill_q;
  way_idx_t               fill_way_d;
  way_idx_t               fill_way_q;
  line_t                  fill_data_q;
  port_id_t               port_id;
  way_idx_t               hit_idx;
  line_t                  hit_line;

  // ------------------------------------------------------------------
  // credits
  // ------------------------------------------------------------------
  // grant and return in one cycle cancel out
  always_comb begin : credit_next
    credit_d = credit_q;
    if (gnt_i && !credit_i) begin
      credit_d = credit_q - 1'b1;
    end else if (credit_i && !gnt_i && (credit_q != MaxCredits)) begin
      credit_d = credit_q + 1'b1;
    end
  end

  // a returned credit is usable from the next cycle
  assign arb_en_o = (credit_q != '0);

  // ------------------------------------------------------------------
  // operation tracking
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q  <= MaxCredits;
      pending_q <= 1'b0;
      fill_q    <= 1'b0;
    end else begin
      credit_q  <= credit_d;
      pending_q <= gnt_i;
      fill_q    <= fill_i;
    end
  end

  // fill way and data for the response
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      fill_way_q  <= fill_way_d;
      fill_data_q <= fill_data_i;
    end
  end

  // ------------------------------------------------------------------
  // response
  // ------------------------------------------------------------------
  // one-hot to binary, hit line mux, zero on a miss
  always_comb begin : encode
    port_id    = '0;
    hit_idx    = '0;
    hit_line   = '0;
    fill_way_d = '0;
    for (int unsigned i = 0; i < `CACHE_NR_PORTS; i++) begin
      if (sel_id_i[i]) port_id = port_id_t'(i);
    end
    for (int unsigned j = 0; j < `CACHE_SET_ASSOC; j++) begin
      if (hit_way_i[j]) begin
        hit_idx  = way_idx_t'(j);
        hit_line = line_rdata_i[j];
      end
      if (victim_way_i[j]) fill_way_d = way_idx_t'(j);
    end
  end

  always_comb begin : resp_build
    resp_o.port = port_id;
    if (fill_q) begin
      resp_o.hit  = 1'b0;
      resp_o.way  = fill_way_q;
      resp_o.data = fill_data_q;
    end else begin
      resp_o.hit  = |hit_way_i;
      resp_o.way  = hit_idx;
      resp_o.data = hit_line;
    end
  end

  assign resp_valid_o = pending_q;

endmodule

// File: logic/cache_pkg.sv
/*
 * cache lookup stage types
 * requests, stored tag entries, data lines and the shared response
 */
`include "cache_settings.svh"

package cache_pkg;

  // ------------------------------------------------------------------
  // scalar fields
  // ------------------------------------------------------------------
  typedef logic [`CACHE_TAG_WIDTH-1:0]   tag_t;
  typedef logic [`CACHE_INDEX_WIDTH-1:0] index_t;
  // tag in the upper bits, set index below it
  typedef logic [`CACHE_ADDR_WIDTH-1:0]  addr_t;
  typedef logic [`CACHE_PORT_WIDTH-1:0]  port_id_t;
  typedef logic [`CACHE_WAY_WIDTH-1:0]   way_idx_t;
  typedef logic [`CACHE_LINE_WIDTH-1:0]  line_t;

  // ------------------------------------------------------------------
  // stored and transported records
  // ------------------------------------------------------------------
  // one tag memory word
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // requester side, we marks a fill
  typedef struct packed {
    addr_t addr;
    logic  we;
    line_t data;
  } cache_req_t;

  // one response per granted operation
  typedef struct packed {
    port_id_t port;
    logic     hit;
    way_idx_t way;
    line_t    data;
  } cache_resp_t;

endpackage

// File: logic/cache_settings.svh
/*
 * cache lookup stage settings
 * port count, associativity, address and line widths, response credits
 */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// requester ports sharing the lookup stage
`define CACHE_NR_PORTS      3
`define CACHE_PORT_WIDTH    $clog2(`CACHE_NR_PORTS)

// ways per set
`define CACHE_SET_ASSOC     4
`define CACHE_WAY_WIDTH     $clog2(`CACHE_SET_ASSOC)

// address split: tag in the upper bits, set index in the lower bits
`define CACHE_INDEX_WIDTH   4
`define CACHE_NUM_SETS      (1 << `CACHE_INDEX_WIDTH)
`define CACHE_TAG_WIDTH     8
`define CACHE_ADDR_WIDTH    (`CACHE_TAG_WIDTH + `CACHE_INDEX_WIDTH)

// one data word per line
`define CACHE_LINE_WIDTH    32

// response stream credits held after reset
`define CACHE_RESP_CREDITS  2
`define CACHE_CREDIT_WIDTH  $clog2(`CACHE_RESP_CREDITS + 1)

`endif

// File: logic/cache_top.sv
/*
 * shared cache lookup stage
 * three requester ports, four ways of tag and data memory,
 * credit-controlled response stream
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top import cache_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic       [`CACHE_NR_PORTS-1:0]  req_valid_i,
  input  cache_req_t [`CACHE_NR_PORTS-1:0]  req_i,
  input  logic                              credit_i,
  output logic       [`CACHE_NR_PORTS-1:0]  gnt_o,
  output logic                              resp_valid_o,
  output cache_resp_t                       resp_o
);

  // arbitration and memory access
  logic                                arb_en;
  logic       [`CACHE_SET_ASSOC-1:0]   mem_req;
  logic                                mem_we;
  index_t                              mem_index;
  tag_entry_t                          tag_wdata;
  line_t                               line_wdata;
  // per-way read data
  tag_entry_t [`CACHE_SET_ASSOC-1:0]   tag_rdata;
  line_t      [`CACHE_SET_ASSOC-1:0]   line_rdata;
  // compare results and fill path
  logic       [`CACHE_SET_ASSOC-1:0]   hit_way;
  logic       [`CACHE_NR_PORTS-1:0]    sel_id;
  logic                                fill;
  index_t                              fill_index;
  logic       [`CACHE_SET_ASSOC-1:0]   victim_way;

  tag_cmp i_tag_cmp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .arb_en_i     (arb_en),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .victim_way_i (victim_way),
    .tag_rdata_i  (tag_rdata),
    .gnt_o        (gnt_o),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_index_o  (mem_index),
    .tag_wdata_o  (tag_wdata),
    .line_wdata_o (line_wdata),
    .hit_way_o    (hit_way),
    .sel_id_o     (sel_id),
    .fill_o       (fill),
    .fill_index_o (fill_index)
  );

  victim_sel i_victim_sel (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .index_i (fill_index),
    .fill_i  (fill),
    .way_o   (victim_way)
  );

  cache_ctrl i_cache_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .credit_i     (credit_i),
    .gnt_i        (|gnt_o),
    .fill_i       (fill),
    .victim_way_i (victim_way),
    .fill_data_i  (line_wdata),
    .hit_way_i    (hit_way),
    .sel_id_i     (sel_id),
    .line_rdata_i (line_rdata),
    .arb_en_o     (arb_en),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  // one tag and one data memory per way, tags cleared on reset
  for (genvar w = 0; w < `CACHE_SET_ASSOC; w++) begin : g_way
    sram_array #(
      .entry_t   (tag_entry_t),
      .NUM_WORDS (`CACHE_NUM_SETS),
      .HAS_RESET (1'b1)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (mem_req[w]),
      .we_i    (mem_we),
      .addr_i  (mem_index),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    sram_array #(
      .entry_t   (line_t),
      .NUM_WORDS (`CACHE_NUM_SETS),
      .HAS_RESET (1'b0)
    ) i_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (mem_req[w]),
      .we_i    (mem_we),
      .addr_i  (mem_index),
      .wdata_i (line_wdata),
      .rdata_o (line_rdata[w])
    );
  end

endmodule

// File: logic/sram_array.sv
/*
 * single-port synchronous memory with registered read data
 * word type is a parameter, optional per-word valid clear on reset
 */
`timescale 1ns/1ps

module sram_array #(
  parameter type         entry_t   = logic,
  parameter int unsigned NUM_WORDS = 16,
  parameter bit          HAS_RESET = 1'b0,
  localparam int unsigned AddrWidth = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  entry_t               wdata_i,
  output entry_t               rdata_o
);

  entry_t mem_q [NUM_WORDS];
  entry_t rdata_q;

  // write or read, never both in one access
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  if (HAS_RESET) begin : g_clear
    // per-word written flag, cleared asynchronously
    logic [NUM_WORDS-1:0] word_vld_q;
    logic                 rd_vld_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        word_vld_q <= '0;
        rd_vld_q   <= 1'b0;
      end else if (req_i) begin
        if (we_i) begin
          word_vld_q[addr_i] <= 1'b1;
        end else begin
          rd_vld_q <= word_vld_q[addr_i];
        end
      end
    end

    // unwritten words read as all zero
    assign rdata_o = rd_vld_q ? rdata_q : '0;
  end else begin : g_plain
    assign rdata_o = rdata_q;
  end

endmodule

// File: logic/tag_cmp.sv
/*
 * tag compare
 * fixed-priority arbitration of the requester ports onto the way memories,
 * tag compare one cycle after the grant
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module tag_cmp import cache_pkg::*; (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    arb_en_i,
  input  logic       [`CACHE_NR_PORTS-1:0]        req_valid_i,
  input  cache_req_t [`CACHE_NR_PORTS-1:0]        req_i,
  input  logic       [`CACHE_SET_ASSOC-1:0]       victim_way_i,
  input  tag_entry_t [`CACHE_SET_ASSOC-1:0]       tag_rdata_i,
  output logic       [`CACHE_NR_PORTS-1:0]        gnt_o,
  output logic       [`CACHE_SET_ASSOC-1:0]       mem_req_o,
  output logic                                    mem_we_o,
  output index_t                                  mem_index_o,
  output tag_entry_t                              tag_wdata_o,
  output line_t                                   line_wdata_o,
  output logic       [`CACHE_SET_ASSOC-1:0]       hit_way_o,
  output logic       [`CACHE_NR_PORTS-1:0]        sel_id_o,
  output logic                                    fill_o,
  output index_t                                  fill_index_o
);

  cache_req_t                    sel_req;
  tag_t                          sel_tag;
  logic                          any_gnt;
  logic                          fill;
  // one-hot port granted in the previous cycle
  logic [`CACHE_NR_PORTS-1:0]    id_q;
  tag_t                          tag_q;

  // ------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------
  // lowest-numbered valid port wins, nothing while credits are out
  always_comb begin : arbiter
    gnt_o   = '0;
    sel_req = '0;
    for (int unsigned i = 0; i < `CACHE_NR_PORTS; i++) begin
      if (arb_en_i && req_valid_i[i] && (gnt_o == '0)) begin
        gnt_o[i] = 1'b1;
        sel_req  = req_i[i];
      end
    end
  end

  assign any_gnt = |gnt_o;
  assign fill    = any_gnt & sel_req.we;
  assign sel_tag = sel_req.addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];

  // lookups read every way, a fill touches the victim way only
  assign mem_req_o    = !any_gnt ? '0 : (fill ? victim_way_i : '1);
  assign mem_we_o     = fill;
  assign mem_index_o  = sel_req.addr[`CACHE_INDEX_WIDTH-1:0];
  assign tag_wdata_o  = '{valid: 1'b1, tag: sel_tag};
  assign line_wdata_o = sel_req.data;

  // victim pointer lookup and advance
  assign fill_o       = fill;
  assign fill_index_o = fill ? mem_index_o : '0;

  // ------------------------------------------------------------------
  // compare side
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else begin
      id_q <= gnt_o;
    end
  end

  // tag of the granted request, held for the compare
  always_ff @(posedge clk_i) begin
    if (any_gnt) begin
      tag_q <= sel_tag;
    end
  end

  for (genvar j = 0; j < `CACHE_SET_ASSOC; j++) begin : g_cmp
    // stored tag matches and the entry is valid
    assign hit_way_o[j] = tag_rdata_i[j].valid && (tag_rdata_i[j].tag == tag_q);
  end

  assign sel_id_o = id_q;

endmodule

// File: logic/victim_sel.sv
/*
 * fill victim selection
 * one round-robin way pointer per set, advanced on each granted fill
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module victim_sel import cache_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  index_t                      index_i,
  input  logic                        fill_i,
  output logic [`CACHE_SET_ASSOC-1:0] way_o
);

  localparam int unsigned LastWay = `CACHE_SET_ASSOC - 1;

  way_idx_t ptr_q [`CACHE_NUM_SETS];
  way_idx_t cur_ptr;

  // pointer of the set being accessed
  assign cur_ptr = ptr_q[index_i];

  // one-hot view for the memory enables
  assign way_o = `CACHE_SET_ASSOC'(1) << cur_ptr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned s = 0; s < `CACHE_NUM_SETS; s++) begin
        ptr_q[s] <= '0;
      end
    end else if (fill_i) begin
      // wrap after the last way
      if (cur_ptr == way_idx_t'(LastWay)) begin
        ptr_q[index_i] <= '0;
      end else begin
        ptr_q[index_i] <= cur_ptr + 1'b1;
      end
    end
  end

endmodule

// File: verif/cache_sva.sv
/*
 * cache lookup stage assertions
 * hit vector shape on the compare side, credit range and grants only while
 * credits remain on the control side
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_sva #(
  parameter bit CheckCredit = 1'b1
) (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic [`CACHE_SET_ASSOC-1:0]         hit_way_i,
  input logic                                gnt_i,
  input logic                                en_i,
  input logic [`CACHE_CREDIT_WIDTH-1:0]      credit_cnt_i
);

  localparam int unsigned CreditWidth = `CACHE_CREDIT_WIDTH;
  localparam logic [CreditWidth-1:0] MaxCredits = CreditWidth'(`CACHE_RESP_CREDITS);

  // number of failed assertions in this instance
  int unsigned fail_cnt = 0;

  if (CheckCredit) begin : g_credit
    // no grant while the response stream has no room
    gnt_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_i |-> en_i)
      else begin
        fail_cnt++;
        $error("grant issued without a credit");
      end

    // counter bounded by the reset value
    credit_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
      credit_cnt_i <= MaxCredits)
      else begin
        fail_cnt++;
        $error("credit count above its reset value");
      end
  end else begin : g_hit
    // at most one way may match a tag
    hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(hit_way_i))
      else begin
        fail_cnt++;
        $error("hit vector has more than one way set");
      end
  end

endmodule

// control side with the credit counter
bind cache_ctrl cache_sva #(.CheckCredit(1'b1)) u_sva_ctrl (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .hit_way_i    ('0),
  .gnt_i        (gnt_i),
  .en_i         (credit_q != '0),
  .credit_cnt_i (credit_q)
);

// compare side with the hit vector
bind tag_cmp cache_sva #(.CheckCredit(1'b0)) u_sva_cmp (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .hit_way_i    (hit_way_o),
  .gnt_i        (1'b0),
  .en_i         (1'b1),
  .credit_cnt_i ('0)
);

// File: verif/cache_tb.sv
/*
 * cache lookup stage testbench
 * LFSR stimulus on three ports, shadow model of tags, data and victim pointers
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tb import cache_pkg::*; ();

  localparam int NP     = `CACHE_NR_PORTS;
  localparam int NW     = `CACHE_SET_ASSOC;
  localparam int NumOps = 6 + 8 + 6 + 6 + 60;

  logic                 clk;
  logic                 rst_n;
  logic [NP-1:0]        req_valid;
  cache_req_t [NP-1:0]  req;
  logic                 credit;
  logic [NP-1:0]        gnt;
  logic                 resp_valid;
  cache_resp_t          resp;

  // per-port pending operations with the front one on the bus
  cache_req_t  port_q [NP][$];
  bit          granted [NP];
  // expected responses in grant order
  cache_resp_t exp_q [$];
  int          exp_cyc_q [$];

  // shadow of the way memories and victim pointers
  logic        sh_valid [`CACHE_NUM_SETS][NW];
  tag_t        sh_tag   [`CACHE_NUM_SETS][NW];
  line_t       sh_data  [`CACHE_NUM_SETS][NW];
  way_idx_t    sh_ptr   [`CACHE_NUM_SETS];

  logic [15:0] lfsr;
  tag_t        next_tag;
  string       cur_test;
  int          cycle;
  int          errors;
  int          checks;
  int          resp_cnt;
  // responses taken but credit not yet handed back
  int          owed;
  // credit count as the DUT should hold it
  int          cred;

  cache_top u_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .credit_i     (credit),
    .gnt_o        (gnt),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic int unsigned rand_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  function automatic cache_req_t make_req(input tag_t tag, input index_t idx,
                                          input logic we, input line_t data);
    cache_req_t r;
    r.addr = {tag, idx};
    r.we   = we;
    r.data = data;
    return r;
  endfunction

  // expected response of one granted operation and shadow update
  function automatic cache_resp_t ref_access(input port_id_t port, input cache_req_t rq);
    cache_resp_t r;
    index_t      idx;
    tag_t        tag;
    way_idx_t    w;
    idx    = rq.addr[`CACHE_INDEX_WIDTH-1:0];
    tag    = rq.addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
    r      = '0;
    r.port = port;
    if (rq.we) begin
      w                 = sh_ptr[idx];
      sh_valid[idx][w]  = 1'b1;
      sh_tag[idx][w]    = tag;
      sh_data[idx][w]   = rq.data;
      // two-bit pointer wraps after way 3
      sh_ptr[idx]       = w + 1'b1;
      r.way             = w;
      r.data            = rq.data;
    end else begin
      for (int j = 0; j < NW; j++) begin
        if (sh_valid[idx][j] && sh_tag[idx][j] == tag) begin
          r.hit  = 1'b1;
          r.way  = way_idx_t'(j);
          r.data = sh_data[idx][j];
        end
      end
    end
    return r;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR %s: %s", cur_test, msg);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  // ------------------------------------------------------------------
  // compare process sampled mid-cycle
  // ------------------------------------------------------------------
  always @(negedge clk) begin : compare
    logic [NP-1:0] exp_gnt;
    cache_resp_t   exp_r;
    int            gcyc;
    if (rst_n) begin
      if (resp_valid) begin
        resp_cnt++;
        owed++;
        if (exp_q.size() == 0) begin
          note_error("response arrived with no operation granted");
        end else begin
          exp_r = exp_q.pop_front();
          gcyc  = exp_cyc_q.pop_front();
          check_val("resp", 64'(exp_r), 64'(resp));
          check_val("latency", 64'(gcyc + 1), 64'(cycle));
        end
      end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] + 1 == cycle) begin
        // the oldest operation is due in this cycle
        void'(exp_q.pop_front());
        void'(exp_cyc_q.pop_front());
        note_error("no response one cycle after the grant");
      end
      // lowest valid port wins while credits remain
      exp_gnt = '0;
      if (cred != 0) begin
        for (int i = 0; i < NP; i++) begin
          if (req_valid[i] && exp_gnt == '0) exp_gnt[i] = 1'b1;
        end
      end
      check_val("gnt", 64'(exp_gnt), 64'(gnt));
      for (int i = 0; i < NP; i++) begin
        if (gnt[i]) begin
          exp_q.push_back(ref_access(port_id_t'(i), req[i]));
          exp_cyc_q.push_back(cycle);
          granted[i] = 1'b1;
        end
      end
      // credit count after the coming edge
      if (|gnt && !credit) begin
        cred--;
      end else if (credit && !(|gnt) && cred < `CACHE_RESP_CREDITS) begin
        cred++;
      end
    end
  end

  // ------------------------------------------------------------------
  // driver
  // ------------------------------------------------------------------
  // mode 0 withholds credits, 1 returns at once, 2 returns at random
  task automatic run_ops(input int mode, input int limit);
    int n;
    bit busy;
    n    = 0;
    busy = 1'b1;
    while (busy && n < limit) begin
      @(posedge clk);
      #1;
      n++;
      busy = 1'b0;
      for (int p = 0; p < NP; p++) begin
        if (granted[p]) begin
          void'(port_q[p].pop_front());
          granted[p] = 1'b0;
        end
        req_valid[p] = (port_q[p].size() != 0);
        if (req_valid[p]) begin
          req[p] = port_q[p][0];
          busy   = 1'b1;
        end
      end
      credit = 1'b0;
      if (owed > 0 && (mode == 1 || (mode == 2 && rand_bits(1) == 1))) begin
        credit = 1'b1;
        owed--;
      end
      if (exp_q.size() != 0 || (mode != 0 && owed != 0)) busy = 1'b1;
    end
  endtask

  // ------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------
  initial begin : main
    int     e0;
    int     base;
    int     sva_fails;
    index_t idx;
    tag_t   t0;
    tag_t   tg;
    logic   we;
    rst_n     = 1'b0;
    req_valid = '0;
    req       = '0;
    credit    = 1'b0;
    lfsr      = 16'd17173;
    next_tag  = '0;
    cycle     = 0;
    errors    = 0;
    checks    = 0;
    resp_cnt  = 0;
    owed      = 0;
    cred      = `CACHE_RESP_CREDITS;
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      sh_ptr[s] = '0;
      for (int w = 0; w < NW; w++) begin
        sh_valid[s][w] = 1'b0;
        sh_tag[s][w]   = '0;
        sh_data[s][w]  = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // every lookup misses on the empty memories
    cur_test = "after_reset";
    e0 = errors;
    for (int k = 0; k < 6; k++) begin
      port_q[rand_bits(2) % NP].push_back(
        make_req(tag_t'(rand_bits(8)), index_t'(rand_bits(4)), 1'b0, '0));
    end
    run_ops(1, 200);
    report_test(cur_test, e0);

    // five fills to one set wrap the victim pointer
    cur_test = "fill_lookup";
    e0  = errors;
    idx = index_t'(5);
    t0  = next_tag;
    for (int k = 0; k < 5; k++) begin
      port_q[0].push_back(make_req(next_tag, idx, 1'b1, line_t'(rand_bits(32))));
      next_tag++;
    end
    port_q[1].push_back(make_req(t0 + 8'd4, idx, 1'b0, '0));
    port_q[1].push_back(make_req(t0, idx, 1'b0, '0));
    port_q[1].push_back(make_req(t0 + 8'd2, idx, 1'b0, '0));
    run_ops(1, 200);
    report_test(cur_test, e0);

    // all ports at once
    cur_test = "priority";
    e0 = errors;
    for (int p = 0; p < NP; p++) begin
      port_q[p].push_back(make_req(t0 + 8'(p), idx, 1'b0, '0));
      port_q[p].push_back(make_req(t0 + 8'(p + 1), idx, 1'b0, '0));
    end
    run_ops(1, 200);
    report_test(cur_test, e0);

    // credits withheld and then returned
    cur_test = "credits";
    e0   = errors;
    base = resp_cnt;
    for (int k = 0; k < 6; k++) begin
      port_q[k % NP].push_back(make_req(t0 + 8'(k), idx, 1'b0, '0));
    end
    run_ops(0, 12);
    check_val("responses without credit", 64'(`CACHE_RESP_CREDITS), 64'(resp_cnt - base));
    run_ops(1, 400);
    check_val("responses total", 64'd6, 64'(resp_cnt - base));
    report_test(cur_test, e0);

    // random fills and lookups over a small pool of sets
    cur_test = "random_mix";
    e0 = errors;
    for (int k = 0; k < 60; k++) begin
      we  = rand_bits(1);
      idx = index_t'(rand_bits(2));
      if (we) begin
        tg = next_tag;
        next_tag++;
      end else begin
        tg = next_tag - 8'd1 - 8'(rand_bits(3));
      end
      port_q[rand_bits(2) % NP].push_back(make_req(tg, idx, we, line_t'(rand_bits(32))));
    end
    run_ops(2, 2000);
    if (exp_q.size() != 0) note_error("operations left without a response");
    report_test(cur_test, e0);

    // failures counted by the bound checkers
    cur_test  = "assertions";
    sva_fails = u_dut.i_cache_ctrl.u_sva_ctrl.fail_cnt + u_dut.i_tag_cmp.u_sva_cmp.fail_cnt;
    if (sva_fails != 0) begin
      note_error($sformatf("%0d assertion failures in the bound checkers", sva_fails));
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // limit of four times 8 cycles of 4 ns for each operation
  initial begin : watchdog
    #(NumOps * 4 * 8 * 4);
    $display("timeout: operations did not complete in time");
    $display("Checks failed");
    $finish;
  end

endmodule
